//--- Bender.yml
package:
  name: ps2_keyboard_device

sources:
  - include_dirs:
      - hw
    files:
      - hw/ps2_kbd_pkg.sv
      - hw/dev_access_if.sv
      - hw/ps2_receive.sv
      - hw/sync_fifo.sv
      - hw/device_special_memory.sv
      - hw/ps2_keyboard_device.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_ps2_keyboard.sv

//--- hw/dev_access_if.sv
/*
	Decoded device access
	One strobe from the bus decoder to the information memory
*/
`default_nettype none

interface dev_access_if
	import ps2_kbd_pkg::*;
();

	// Single-cycle request strobe
	logic      req;
	// 1 for write
	logic      write;
	// Word index inside the memory
	logic [7:0] index;
	dev_word_t wdata;
	// Valid the cycle after req
	dev_word_t rdata;

	modport master (output req, output write, output index, output wdata, input rdata);
	modport target (input req, input write, input index, input wdata, output rdata);

endinterface

`default_nettype wire

//--- hw/device_special_memory.sv
/*
	Device information memory
	256 words, word 0 is the device kind and word 1 the version,
	both read-only. Read data is registered one cycle after the request.
*/
`default_nettype none
`include "ps2_kbd_defs.svh"

module device_special_memory
	import ps2_kbd_pkg::*;
(
	input wire              iCLOCK,
	input wire              inRESET,
	dev_access_if.target    acc
);

	localparam logic [7:0] IDX_KIND = 8'd0;
	localparam logic [7:0] IDX_VERSION = 8'd1;

	dev_word_t mem [0:255];

	// Stores at the ID indexes are shadowed on read
	always_ff @(posedge iCLOCK) begin
		if (acc.req && acc.write) begin
			mem[acc.index] <= acc.wdata;
		end
	end

	// Registered read port
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			acc.rdata <= '0;
		end else if (acc.req && !acc.write) begin
			// ID words come from constants
			case (acc.index)
				IDX_KIND: acc.rdata <= `PS2_KBD_DEVICE_KIND;
				IDX_VERSION: acc.rdata <= `PS2_KBD_VERSION;
				default: acc.rdata <= mem[acc.index];
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/ps2_kbd_defs.svh
/*
	PS/2 keyboard controller parameters
	Bus addresses, queue size, identification words and receiver timeout
*/
`ifndef PS2_KBD_DEFS_SVH
`define PS2_KBD_DEFS_SVH

// Scancode port, one word
`define PS2_KBD_DATA_ADDR       32'h0000_0400
// First address past the information memory
`define PS2_KBD_SPECIAL_LIMIT   32'h0000_0400

// Key queue size and pointer width
`define PS2_KBD_FIFO_DEPTH      32
`define PS2_KBD_FIFO_AW         5

// Read-only identification words
`define PS2_KBD_DEVICE_KIND     32'h0000_000A
`define PS2_KBD_VERSION         32'h0000_0001

// System cycles without a PS/2 clock edge before a partial frame is dropped
`define PS2_IDLE_TIMEOUT        4096

`endif

//--- hw/ps2_kbd_pkg.sv
/*
	PS/2 keyboard controller types
	Scancode, device bus word and receiver FSM state
*/
`default_nettype none

package ps2_kbd_pkg;

	// Raw keyboard scancode
	typedef logic [7:0] scancode_t;

	// Device bus data word
	typedef logic [31:0] dev_word_t;

	// Frame receiver states
	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0,
		// Start bit seen, collecting the rest
		RX_SHIFT = 2'd1,
		// Eleven bits in, frame checked here
		RX_DONE  = 2'd2
	} ps2_rx_state_t;

endpackage

`default_nettype wire

//--- hw/ps2_keyboard_device.sv
/*
	PS/2 keyboard controller top
	Addresses below 0x400 hit the information memory, 0x400 pops one
	queued key as {valid, scancode}. Each accepted key raises one
	interrupt, held back while irq_busy is high.
*/
`default_nettype none
`include "ps2_kbd_defs.svh"

module ps2_keyboard_device
	import ps2_kbd_pkg::*;
(
	input wire              iCLOCK,
	input wire              inRESET,
	// Bus request
	input wire              dev_req,
	input wire              dev_rw,
	input wire dev_word_t   dev_addr,
	input wire dev_word_t   dev_wdata,
	// Bus response
	output logic            resp_req,
	output dev_word_t       resp_data,
	// Interrupt
	output logic            irq_req,
	input wire              irq_busy,
	// Keyboard pins
	input wire              ps2_clock,
	input wire              ps2_data
);

	localparam int IRQ_W = `PS2_KBD_FIFO_AW;

	logic       key_valid;
	scancode_t  key_code;
	logic       fifo_full;
	logic       fifo_empty;
	scancode_t  fifo_rd_data;
	logic       key_accept;
	logic       mem_sel;
	logic       data_rd;
	logic       mem_sel_q;
	dev_word_t  key_word_q;
	logic [IRQ_W-1:0] irq_cnt;
	logic       irq_full;

	dev_access_if acc_if ();

	ps2_receive rx_i (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.ps2_clock (ps2_clock),
		.ps2_data  (ps2_data),
		.key_valid (key_valid),
		.key_code  (key_code)
	);

	// Address decode
	assign mem_sel = dev_req && (dev_addr < `PS2_KBD_SPECIAL_LIMIT);
	assign data_rd = dev_req && !dev_rw && (dev_addr == `PS2_KBD_DATA_ADDR);

	// Byte address to word index
	assign acc_if.req = mem_sel;
	assign acc_if.write = dev_rw;
	assign acc_if.index = dev_addr[9:2];
	assign acc_if.wdata = dev_wdata;

	device_special_memory mem_i (
		.iCLOCK  (iCLOCK),
		.inRESET (inRESET),
		.acc     (acc_if.target)
	);

	// Key dropped if either queue or interrupt count is full
	assign key_accept = key_valid && !fifo_full && !irq_full;

	sync_fifo #(
		.DEPTH (`PS2_KBD_FIFO_DEPTH),
		.AW    (`PS2_KBD_FIFO_AW)
	) fifo_i (
		.iCLOCK  (iCLOCK),
		.inRESET (inRESET),
		.wr_en   (key_accept),
		.wr_data (key_code),
		.full    (fifo_full),
		.rd_en   (data_rd && !fifo_empty),
		.rd_data (fifo_rd_data),
		.empty   (fifo_empty)
	);

	// Pending interrupts, saturating at all ones
	assign irq_full = &irq_cnt;
	assign irq_req = (irq_cnt != '0) && !irq_busy;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			irq_cnt <= '0;
		end else if (key_accept && !irq_req) begin
			irq_cnt <= irq_cnt + 1'b1;
		end else if (irq_req && !key_accept) begin
			irq_cnt <= irq_cnt - 1'b1;
		end
	end

	// Response one cycle after a read, writes stay silent
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			resp_req <= 1'b0;
			mem_sel_q <= 1'b0;
			key_word_q <= '0;
		end else begin
			resp_req <= (mem_sel && !dev_rw) || data_rd;
			mem_sel_q <= mem_sel;
			if (data_rd) begin
				// Bit 8 flags a real key, empty queue reads zero
				key_word_q <= fifo_empty ? '0 : dev_word_t'({1'b1, fifo_rd_data});
			end
		end
	end

	// Memory word is already registered inside the memory
	assign resp_data = mem_sel_q ? acc_if.rdata : key_word_q;

endmodule

`default_nettype wire

//--- hw/ps2_receive.sv
/*
	PS/2 frame receiver
	Synchronizes the keyboard pins and shifts in 11-bit frames on falling
	PS/2 clock edges. Good frames (start 0, odd parity, stop 1) give one
	key_valid strobe. Stalled frames are dropped after an idle timeout.
*/
`default_nettype none
`include "ps2_kbd_defs.svh"

module ps2_receive
	import ps2_kbd_pkg::*;
(
	input wire              iCLOCK,
	input wire              inRESET,
	// Keyboard pins
	input wire              ps2_clock,
	input wire              ps2_data,
	// Received key
	output logic            key_valid,
	output scancode_t       key_code
);

	localparam int FRAME_BITS = 11;
	localparam int TO_W = $clog2(`PS2_IDLE_TIMEOUT);
	localparam logic [TO_W-1:0] TO_LAST = TO_W'(`PS2_IDLE_TIMEOUT - 1);

	// Two-stage synchronizers
	logic clk_s1;
	logic clk_s2;
	logic clk_prev;
	logic data_s1;
	logic data_s2;
	logic clk_fall;

	ps2_rx_state_t       state;
	logic [3:0]          bit_cnt;
	logic [TO_W-1:0]     idle_cnt;
	logic [FRAME_BITS-1:0] frame;
	logic                frame_ok;

	// Pins idle high
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			clk_s1 <= 1'b1;
			clk_s2 <= 1'b1;
			clk_prev <= 1'b1;
			data_s1 <= 1'b1;
			data_s2 <= 1'b1;
		end else begin
			clk_s1 <= ps2_clock;
			clk_s2 <= clk_s1;
			clk_prev <= clk_s2;
			data_s1 <= ps2_data;
			data_s2 <= data_s1;
		end
	end

	// Keyboard drives data, host samples on falling clock
	assign clk_fall = clk_prev & ~clk_s2;

	// Frame FSM
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= RX_IDLE;
			bit_cnt <= 4'd0;
			idle_cnt <= '0;
		end else begin
			case (state)
				RX_IDLE: begin
					idle_cnt <= '0;
					if (clk_fall) begin
						// Start bit taken
						bit_cnt <= 4'd1;
						state <= RX_SHIFT;
					end
				end
				RX_SHIFT: begin
					if (clk_fall) begin
						idle_cnt <= '0;
						bit_cnt <= bit_cnt + 4'd1;
						if (bit_cnt == 4'(FRAME_BITS - 1)) begin
							state <= RX_DONE;
						end
					end else if (idle_cnt == TO_LAST) begin
						// Keyboard went quiet mid-frame
						state <= RX_IDLE;
						bit_cnt <= 4'd0;
					end else begin
						idle_cnt <= idle_cnt + 1'b1;
					end
				end
				RX_DONE: begin
					// One cycle for the strobe
					state <= RX_IDLE;
					bit_cnt <= 4'd0;
				end
				default: begin
					state <= RX_IDLE;
					bit_cnt <= 4'd0;
				end
			endcase
		end
	end

	// Shift right, LSB arrives first
	always_ff @(posedge iCLOCK) begin
		if (clk_fall && state != RX_DONE) begin
			frame <= {data_s2, frame[FRAME_BITS-1:1]};
		end
	end

	// frame[0] start, [8:1] data, [9] parity, [10] stop
	assign frame_ok = !frame[0] && frame[10] && (^frame[9:1]);

	assign key_valid = (state == RX_DONE) && frame_ok;
	assign key_code = frame[8:1];

endmodule

`default_nettype wire

//--- hw/sync_fifo.sv
/*
	Scancode queue
	Synchronous circular buffer, head visible without read latency
*/
`default_nettype none

module sync_fifo
	import ps2_kbd_pkg::*;
#(
	parameter int DEPTH = 32,
	parameter int AW = 5
)(
	input wire              iCLOCK,
	input wire              inRESET,
	// Write side
	input wire              wr_en,
	input wire scancode_t   wr_data,
	output logic            full,
	// Read side
	input wire              rd_en,
	output scancode_t       rd_data,
	output logic            empty
);

	scancode_t      mem [0:DEPTH-1];
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	// One extra bit to hold DEPTH
	logic [AW:0]    count;
	logic           do_wr;
	logic           do_rd;

	assign full = (count == (AW+1)'(DEPTH));
	assign empty = (count == '0);

	// Overflow and underflow are dropped
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop keeps the level
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// First word fall through
	assign rd_data = mem[rd_ptr];

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/ps2_kbd_pkg.sv
hw/dev_access_if.sv
hw/ps2_receive.sv
hw/sync_fifo.sv
hw/device_special_memory.sv
hw/ps2_keyboard_device.sv
test/tb_ps2_keyboard.sv

//--- test/tb_ps2_keyboard.sv
/*
	PS/2 keyboard controller testbench
	Keyboard frame model, bus read and write tasks, checks on the
	information memory, the key queue and the interrupt line
*/
`default_nettype none
`include "ps2_kbd_defs.svh"

module tb_ps2_keyboard
	import ps2_kbd_pkg::*;
();

	localparam dev_word_t DATA_ADDR = `PS2_KBD_DATA_ADDR;
	// System cycles per PS/2 clock phase
	localparam int PS2_HALF = 20;
	localparam int RESP_TIMEOUT = 16;
	localparam int IRQ_TIMEOUT = 200;

	logic       iCLOCK;
	logic       inRESET;
	logic       dev_req;
	logic       dev_rw;
	dev_word_t  dev_addr;
	dev_word_t  dev_wdata;
	logic       resp_req;
	dev_word_t  resp_data;
	logic       irq_req;
	logic       irq_busy;
	logic       ps2_clock;
	logic       ps2_data;

	integer     seed;
	int         errors;
	int         checks;
	// irq_req high cycles since last clear
	int         irq_seen;
	dev_word_t  shadow [0:255];
	// Keys sent and not yet read back
	scancode_t  sent [$];

	ps2_keyboard_device dut_i (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.dev_req   (dev_req),
		.dev_rw    (dev_rw),
		.dev_addr  (dev_addr),
		.dev_wdata (dev_wdata),
		.resp_req  (resp_req),
		.resp_data (resp_data),
		.irq_req   (irq_req),
		.irq_busy  (irq_busy),
		.ps2_clock (ps2_clock),
		.ps2_data  (ps2_data)
	);

	always #4 iCLOCK = ~iCLOCK;

	// Each high cycle is one delivered interrupt
	always @(negedge iCLOCK) begin
		if (inRESET && irq_req) begin
			irq_seen = irq_seen + 1;
		end
	end

	// Reads up to the data port answer in the very next cycle
	read_resp: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(dev_req && !dev_rw && dev_addr <= DATA_ADDR) |=> resp_req)
		else begin
			errors = errors + 1;
			$display("read got no response in the following cycle");
		end

	// Writes stay silent
	write_silent: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(dev_req && dev_rw) |=> !resp_req)
		else begin
			errors = errors + 1;
			$display("write produced a bus response");
		end

	// No response without a read one cycle before
	resp_origin: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		resp_req |-> $past(dev_req && !dev_rw && dev_addr <= DATA_ADDR))
		else begin
			errors = errors + 1;
			$display("bus response appeared without a matching read");
		end

	task automatic check_value(input string name, input dev_word_t expected,
			input dev_word_t actual);
		checks = checks + 1;
		assert (actual === expected) else begin
			errors = errors + 1;
			$display("ERR %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic write_word(input dev_word_t addr, input dev_word_t data);
		@(posedge iCLOCK);
		dev_req <= 1'b1;
		dev_rw <= 1'b1;
		dev_addr <= addr;
		dev_wdata <= data;
		@(posedge iCLOCK);
		dev_req <= 1'b0;
	endtask

	task automatic read_word(input dev_word_t addr, output dev_word_t data);
		int waited;
		@(posedge iCLOCK);
		dev_req <= 1'b1;
		dev_rw <= 1'b0;
		dev_addr <= addr;
		@(posedge iCLOCK);
		dev_req <= 1'b0;
		data = '0;
		// Response arrives one cycle after the strobe
		for (waited = 0; waited < RESP_TIMEOUT; waited++) begin
			@(negedge iCLOCK);
			if (resp_req) begin
				break;
			end
		end
		if (waited == RESP_TIMEOUT) begin
			errors = errors + 1;
			$display("timeout waiting for the response to a read at %h", addr);
		end else begin
			data = resp_data;
		end
	endtask

	// Start, eight data bits LSB first, odd parity, stop
	task automatic send_frame(input scancode_t code, input logic bad_parity);
		logic [10:0] bits;
		int i;
		bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
		for (i = 0; i < 11; i++) begin
			@(posedge iCLOCK);
			ps2_data <= bits[i];
			repeat (PS2_HALF) @(posedge iCLOCK);
			ps2_clock <= 1'b0;
			repeat (PS2_HALF) @(posedge iCLOCK);
			ps2_clock <= 1'b1;
		end
		@(posedge iCLOCK);
		ps2_data <= 1'b1;
	endtask

	task automatic wait_irq_idle();
		int waited;
		for (waited = 0; waited < IRQ_TIMEOUT; waited++) begin
			@(negedge iCLOCK);
			if (!irq_req) begin
				break;
			end
		end
		if (waited == IRQ_TIMEOUT) begin
			errors = errors + 1;
			$display("interrupt line stayed high past its timeout");
		end
	endtask

	// Pops keys at the data port in arrival order
	task automatic read_keys(input string name, input int count);
		dev_word_t rd;
		int i;
		for (i = 0; i < count; i++) begin
			read_word(DATA_ADDR, rd);
			check_value(name, {23'd0, 1'b1, sent.pop_front()}, rd);
		end
	endtask

	task automatic queue_key(input scancode_t code);
		sent.push_back(code);
		send_frame(code, 1'b0);
	endtask

	initial begin
		dev_word_t rd;
		int i;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		dev_req = 1'b0;
		dev_rw = 1'b0;
		dev_addr = '0;
		dev_wdata = '0;
		irq_busy = 1'b0;
		ps2_clock = 1'b1;
		ps2_data = 1'b1;
		seed = 32'h55d9;
		errors = 0;
		checks = 0;
		irq_seen = 0;
		repeat (8) @(posedge iCLOCK);
		inRESET <= 1'b1;

		// Quiet outputs and empty queue after reset
		@(negedge iCLOCK);
		check_value("reset_resp_req", 32'd0, {31'd0, resp_req});
		check_value("reset_irq_req", 32'd0, {31'd0, irq_req});
		read_word(DATA_ADDR, rd);
		check_value("reset_data_port", 32'd0, rd);

		// ID words hold through writes
		write_word(32'h0, 32'hFFFF_FFFF);
		write_word(32'h4, 32'h1234_5678);
		read_word(32'h0, rd);
		check_value("id_kind", `PS2_KBD_DEVICE_KIND, rd);
		read_word(32'h4, rd);
		check_value("id_version", `PS2_KBD_VERSION, rd);

		for (i = 2; i < 256; i++) begin
			shadow[i] = $random(seed);
			write_word(dev_word_t'(i * 4), shadow[i]);
		end
		for (i = 2; i < 256; i++) begin
			read_word(dev_word_t'(i * 4), rd);
			check_value("mem_readback", shadow[i], rd);
		end

		// Reads past the data port get no response
		@(posedge iCLOCK);
		dev_req <= 1'b1;
		dev_rw <= 1'b0;
		dev_addr <= DATA_ADDR + 32'd4;
		@(posedge iCLOCK);
		dev_req <= 1'b0;
		@(negedge iCLOCK);
		check_value("unmapped_read", 32'd0, {31'd0, resp_req});

		// Ten keys give one interrupt each
		irq_seen = 0;
		for (i = 0; i < 10; i++) begin
			queue_key(scancode_t'($random(seed)));
		end
		wait_irq_idle();
		check_value("irq_per_key", 32'd10, irq_seen);
		read_keys("key_order", 10);
		read_word(DATA_ADDR, rd);
		check_value("key_drained", 32'd0, rd);

		// Bad parity frame vanishes
		irq_seen = 0;
		send_frame(scancode_t'($random(seed)), 1'b1);
		wait_irq_idle();
		check_value("bad_parity_irq", 32'd0, irq_seen);
		read_word(DATA_ADDR, rd);
		check_value("bad_parity_data", 32'd0, rd);
		queue_key(scancode_t'($random(seed)));
		wait_irq_idle();
		check_value("after_bad_irq", 32'd1, irq_seen);
		read_keys("after_bad_key", 1);

		// Interrupts held while busy
		@(posedge iCLOCK);
		irq_busy <= 1'b1;
		irq_seen = 0;
		for (i = 0; i < 3; i++) begin
			queue_key(scancode_t'($random(seed)));
		end
		check_value("held_irq", 32'd0, irq_seen);
		@(posedge iCLOCK);
		irq_busy <= 1'b0;
		wait_irq_idle();
		check_value("released_irq", 32'd3, irq_seen);
		read_keys("held_keys", 3);

		// 33 keys against a counter that tops out at 31
		@(posedge iCLOCK);
		irq_busy <= 1'b1;
		irq_seen = 0;
		for (i = 0; i < 33; i++) begin
			queue_key(scancode_t'($random(seed)));
		end
		check_value("sat_held_irq", 32'd0, irq_seen);
		read_keys("sat_keys", 31);
		sent.delete();
		read_word(DATA_ADDR, rd);
		check_value("sat_dropped", 32'd0, rd);
		@(posedge iCLOCK);
		irq_busy <= 1'b0;
		wait_irq_idle();
		check_value("sat_irq", 32'd31, irq_seen);

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
